//--- source/alu.sv
`default_nettype none
`timescale 1ns/1ns

module alu (
    input  rvPkg::aluOp_e aluOp,
    input  rvPkg::word_t  srcA,
    input  rvPkg::word_t  srcB,
    output rvPkg::word_t  result,
    output logic          zero
);
    import rvPkg::*;

    always_comb begin
        case (aluOp)
            aluAdd: result = srcA + srcB;
            aluSub: result = srcA - srcB;
            aluAnd: result = srcA & srcB;
            aluOr:  result = srcA | srcB;
            // signed compare
            aluSlt: result = {{(xlen - 1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: result = '0;
        endcase
    end

    // beq uses sub, equal operands give zero
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`default_nettype none
`timescale 1ns/1ns

module controlUnit (
    input  rvPkg::instr_u      instrD,
    output rvPkg::decodeCtrl_t ctrlD
);
    import rvPkg::*;

    aluOp_e arithOp;
    logic   arithOk;

    // funct3 picks the operation, funct7 bit 5 turns add into sub for R-type
    always_comb begin
        arithOk = 1'b1;
        case (instrD.rType.funct3)
            3'b000: begin
                if (instrD.rType.opcode == opR && instrD.rType.funct7[5]) begin
                    arithOp = aluSub;
                end else begin
                    arithOp = aluAdd;
                end
            end
            3'b010: arithOp = aluSlt;
            3'b110: arithOp = aluOr;
            3'b111: arithOp = aluAnd;
            default: begin
                arithOp = aluAdd;
                arithOk = 1'b0;
            end
        endcase
    end

    always_comb begin
        // anything not recognised stays a bubble
        ctrlD = '0;
        case (instrD.rType.opcode)
            opR: begin
                ctrlD.regWrite = arithOk;
                ctrlD.aluOp    = arithOp;
            end
            opImm: begin
                ctrlD.regWrite = arithOk;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.aluOp    = arithOp;
                ctrlD.immSel   = immI;
            end
            opLoad: begin
                ctrlD.regWrite  = (instrD.iType.funct3 == 3'b010);
                ctrlD.resultSel = resMem;
                ctrlD.aluSrc    = 1'b1;
                ctrlD.immSel    = immI;
            end
            opStore: begin
                ctrlD.memWrite = (instrD.sType.funct3 == 3'b010);
                ctrlD.aluSrc   = 1'b1;
                ctrlD.immSel   = immS;
            end
            opBranch: begin
                // beq only, compare by subtraction
                ctrlD.branch = (instrD.iType.funct3 == 3'b000);
                ctrlD.aluOp  = aluSub;
                ctrlD.immSel = immB;
            end
            opJal: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSel = resPc4;
                ctrlD.jump      = 1'b1;
                ctrlD.immSel    = immJ;
            end
            opJalr: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSel = resPc4;
                ctrlD.jump      = 1'b1;
                ctrlD.jalr      = 1'b1;
                ctrlD.aluSrc    = 1'b1;
                ctrlD.immSel    = immI;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/datapath.sv
`default_nettype none
`timescale 1ns/1ns

module datapath (
    input  logic               clk,
    input  logic               rst,
    input  rvPkg::decodeCtrl_t ctrlD,
    input  rvPkg::hazardCtrl_t hzCtrl,
    output rvPkg::exHazard_t   hzInfo,
    output rvPkg::instr_u      instrD,
    output rvPkg::word_t       instrAddr,
    input  rvPkg::word_t       instr,
    output rvPkg::word_t       memAddr,
    output rvPkg::word_t       memWriteData,
    output logic               memWrite,
    input  rvPkg::word_t       memReadData,
    output rvPkg::word_t       a0
);
    import rvPkg::*;

    word_t  pcF;
    word_t  pcPlus4F;
    word_t  pcNextF;
    ifId_t  ifId;
    idEx_t  idEx;
    exMem_t exMem;
    memWb_t memWb;

    word_t  rd1D;
    word_t  rd2D;
    word_t  immD;
    word_t  srcAE;
    word_t  srcBE;
    word_t  writeDataE;
    word_t  aluResultE;
    word_t  pcTargetE;
    word_t  redirectTargetE;
    logic   zeroE;
    logic   pcRedirectE;
    word_t  resultW;

    // fetch
    assign instrAddr = pcF;
    assign pcPlus4F  = pcF + 32'd4;
    assign pcNextF   = pcRedirectE ? redirectTargetE : pcPlus4F;

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= '0;
        end else if (!hzCtrl.stallF) begin
            pcF <= pcNextF;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || hzCtrl.flushD) begin
            ifId <= '0;
        end else if (!hzCtrl.stallD) begin
            ifId.instr   <= instr;
            ifId.pc      <= pcF;
            ifId.pcPlus4 <= pcPlus4F;
        end
    end

    // decode
    assign instrD = ifId.instr;

    regFile rf (
        .clk (clk),
        .rst (rst),
        .rs1 (ifId.instr.rType.rs1),
        .rs2 (ifId.instr.rType.rs2),
        .rd1 (rd1D),
        .rd2 (rd2D),
        .we  (memWb.regWrite),
        .rd  (memWb.rd),
        .wd  (resultW),
        .a0  (a0)
    );

    immExtend ext (
        .instrD (ifId.instr),
        .immSel (ctrlD.immSel),
        .immD   (immD)
    );

    always_ff @(posedge clk) begin
        if (rst || hzCtrl.flushE) begin
            idEx <= '0;
        end else begin
            idEx.ctrl    <= ctrlD;
            idEx.rd1     <= rd1D;
            idEx.rd2     <= rd2D;
            idEx.pc      <= ifId.pc;
            idEx.imm     <= immD;
            idEx.pcPlus4 <= ifId.pcPlus4;
            idEx.rs1     <= ifId.instr.rType.rs1;
            idEx.rs2     <= ifId.instr.rType.rs2;
            idEx.rd      <= ifId.instr.rType.rd;
        end
    end

    // execute, forwarding muxes ahead of the ALU
    assign srcAE = (hzCtrl.forwardAE == fwdMem) ? exMem.aluResult :
                   (hzCtrl.forwardAE == fwdWb)  ? resultW : idEx.rd1;
    assign writeDataE = (hzCtrl.forwardBE == fwdMem) ? exMem.aluResult :
                        (hzCtrl.forwardBE == fwdWb)  ? resultW : idEx.rd2;
    assign srcBE = idEx.ctrl.aluSrc ? idEx.imm : writeDataE;

    alu alu (
        .aluOp  (idEx.ctrl.aluOp),
        .srcA   (srcAE),
        .srcB   (srcBE),
        .result (aluResultE),
        .zero   (zeroE)
    );

    // branch and jal go to pc+imm, jalr to rs1+imm with bit 0 cleared
    assign pcTargetE       = idEx.pc + idEx.imm;
    assign redirectTargetE = idEx.ctrl.jalr ? {aluResultE[xlen-1:1], 1'b0} : pcTargetE;
    assign pcRedirectE     = (idEx.ctrl.branch && zeroE) || idEx.ctrl.jump;

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.resultSel <= idEx.ctrl.resultSel;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.aluResult <= aluResultE;
            exMem.writeData <= writeDataE;
            exMem.pcPlus4   <= idEx.pcPlus4;
            exMem.rd        <= idEx.rd;
        end
    end

    // memory, the data RAM sits outside
    assign memAddr      = exMem.aluResult;
    assign memWriteData = exMem.writeData;
    assign memWrite     = exMem.memWrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb.regWrite  <= exMem.regWrite;
            memWb.resultSel <= exMem.resultSel;
            memWb.aluResult <= exMem.aluResult;
            memWb.readData  <= memReadData;
            memWb.pcPlus4   <= exMem.pcPlus4;
            memWb.rd        <= exMem.rd;
        end
    end

    // writeback
    always_comb begin
        case (memWb.resultSel)
            resMem:  resultW = memWb.readData;
            resPc4:  resultW = memWb.pcPlus4;
            default: resultW = memWb.aluResult;
        endcase
    end

    // register indices and stage state for the hazard unit
    assign hzInfo.rs1D          = ifId.instr.rType.rs1;
    assign hzInfo.rs2D          = ifId.instr.rType.rs2;
    assign hzInfo.rs1E          = idEx.rs1;
    assign hzInfo.rs2E          = idEx.rs2;
    assign hzInfo.rdE           = idEx.rd;
    assign hzInfo.rdM           = exMem.rd;
    assign hzInfo.rdW           = memWb.rd;
    assign hzInfo.resultIsLoadE = (idEx.ctrl.resultSel == resMem);
    assign hzInfo.regWriteM     = exMem.regWrite;
    assign hzInfo.regWriteW     = memWb.regWrite;
    assign hzInfo.pcRedirectE   = pcRedirectE;

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`default_nettype none
`timescale 1ns/1ns

module hazardUnit (
    input  rvPkg::exHazard_t   hzInfo,
    output rvPkg::hazardCtrl_t hzCtrl
);
    import rvPkg::*;

    logic loadUse;

    // memory stage wins over writeback, x0 never forwarded
    function automatic fwdSel_e pickFwd(regAddr_t rsE, exHazard_t info);
        if (info.regWriteM && info.rdM != '0 && info.rdM == rsE) begin
            return fwdMem;
        end
        if (info.regWriteW && info.rdW != '0 && info.rdW == rsE) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    // load in execute feeding the instruction in decode
    assign loadUse = hzInfo.resultIsLoadE && hzInfo.rdE != '0 &&
                     (hzInfo.rdE == hzInfo.rs1D || hzInfo.rdE == hzInfo.rs2D);

    always_comb begin
        hzCtrl.forwardAE = pickFwd(hzInfo.rs1E, hzInfo);
        hzCtrl.forwardBE = pickFwd(hzInfo.rs2E, hzInfo);
        hzCtrl.stallF    = loadUse;
        hzCtrl.stallD    = loadUse;
        // redirect squashes decode and execute
        hzCtrl.flushD    = hzInfo.pcRedirectE;
        hzCtrl.flushE    = hzInfo.pcRedirectE || loadUse;
    end

endmodule

`default_nettype wire

//--- source/immExtend.sv
`default_nettype none
`timescale 1ns/1ns

module immExtend (
    input  rvPkg::instr_u  instrD,
    input  rvPkg::immSel_e immSel,
    output rvPkg::word_t   immD
);
    import rvPkg::*;

    logic [19:0] jField;

    // instr[31:12] holds the scrambled J immediate
    assign jField = {instrD.iType.imm, instrD.iType.rs1, instrD.iType.funct3};

    always_comb begin
        case (immSel)
            immI: immD = {{20{instrD.iType.imm[11]}}, instrD.iType.imm};
            immS: immD = {{20{instrD.sType.immHi[6]}}, instrD.sType.immHi, instrD.sType.immLo};
            // B reuses the S fields, bit 11 sits in immLo[0]
            immB: begin
                immD = {{20{instrD.sType.immHi[6]}}, instrD.sType.immLo[0],
                        instrD.sType.immHi[5:0], instrD.sType.immLo[4:1], 1'b0};
            end
            immJ: immD = {{12{jField[19]}}, jField[7:0], jField[8], jField[18:9], 1'b0};
            default: immD = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/pipelineCpu.sv
`default_nettype none
`timescale 1ns/1ns

module pipelineCpu (
    input  logic         clk,
    input  logic         rst,
    output rvPkg::word_t instrAddr,
    input  rvPkg::word_t instr,
    output rvPkg::word_t memAddr,
    output rvPkg::word_t memWriteData,
    output logic         memWrite,
    input  rvPkg::word_t memReadData,
    output rvPkg::word_t a0
);
    import rvPkg::*;

    instr_u      instrD;
    decodeCtrl_t ctrlD;
    exHazard_t   hzInfo;
    hazardCtrl_t hzCtrl;

    controlUnit cu (
        .instrD (instrD),
        .ctrlD  (ctrlD)
    );

    datapath dp (
        .clk          (clk),
        .rst          (rst),
        .ctrlD        (ctrlD),
        .hzCtrl       (hzCtrl),
        .hzInfo       (hzInfo),
        .instrD       (instrD),
        .instrAddr    (instrAddr),
        .instr        (instr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memReadData  (memReadData),
        .a0           (a0)
    );

    hazardUnit hu (
        .hzInfo (hzInfo),
        .hzCtrl (hzCtrl)
    );

endmodule

`default_nettype wire

//--- source/regFile.sv
`default_nettype none
`timescale 1ns/1ns

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    output rvPkg::word_t    rd1,
    output rvPkg::word_t    rd2,
    input  logic           we,
    input  rvPkg::regAddr_t rd,
    input  rvPkg::word_t    wd,
    output rvPkg::word_t    a0
);
    import rvPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 reads zero, a write in the same cycle is passed straight through
    assign rd1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

    // debug tap on x10
    assign a0 = regs[10];

endmodule

`default_nettype wire

//--- source/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      regAddr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // one instruction word, seen through the R, I and S layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            regAddr_t   rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            regAddr_t    rs1;
            logic [2:0]  funct3;
            regAddr_t    rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
    } instr_u;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_e;
    typedef enum logic [2:0] {immI, immS, immB, immJ} immSel_e;
    typedef enum logic [1:0] {resAlu, resMem, resPc4} resultSel_e;
    // encodings follow the usual 00 register, 01 writeback, 10 memory
    typedef enum logic [1:0] {fwdReg, fwdWb, fwdMem} fwdSel_e;

    typedef struct packed {
        logic       regWrite;
        resultSel_e resultSel;
        logic       memWrite;
        logic       branch;
        logic       jump;
        logic       jalr;
        logic       aluSrc;
        aluOp_e     aluOp;
        immSel_e    immSel;
    } decodeCtrl_t;

    typedef struct packed {
        regAddr_t rs1D;
        regAddr_t rs2D;
        regAddr_t rs1E;
        regAddr_t rs2E;
        regAddr_t rdE;
        regAddr_t rdM;
        regAddr_t rdW;
        logic     resultIsLoadE;
        logic     regWriteM;
        logic     regWriteW;
        logic     pcRedirectE;
    } exHazard_t;

    typedef struct packed {
        logic    stallF;
        logic    stallD;
        logic    flushD;
        logic    flushE;
        fwdSel_e forwardAE;
        fwdSel_e forwardBE;
    } hazardCtrl_t;

    // pipeline registers, all zero means bubble
    typedef struct packed {
        instr_u instr;
        word_t  pc;
        word_t  pcPlus4;
    } ifId_t;

    typedef struct packed {
        decodeCtrl_t ctrl;
        word_t       rd1;
        word_t       rd2;
        word_t       pc;
        word_t       imm;
        word_t       pcPlus4;
        regAddr_t    rs1;
        regAddr_t    rs2;
        regAddr_t    rd;
    } idEx_t;

    typedef struct packed {
        logic       regWrite;
        resultSel_e resultSel;
        logic       memWrite;
        word_t      aluResult;
        word_t      writeData;
        word_t      pcPlus4;
        regAddr_t   rd;
    } exMem_t;

    typedef struct packed {
        logic       regWrite;
        resultSel_e resultSel;
        word_t      aluResult;
        word_t      readData;
        word_t      pcPlus4;
        regAddr_t   rd;
    } memWb_t;

endpackage

`default_nettype wire

//--- sources.f
source/rvPkg.sv
source/controlUnit.sv
source/immExtend.sv
source/regFile.sv
source/alu.sv
source/hazardUnit.sv
source/datapath.sv
source/pipelineCpu.sv
tests/pipelineCpuTb.sv

//--- tests/pipelineCpuTb.sv
`default_nettype none
`timescale 1ns/1ns

module pipelineCpuTb;
    import rvPkg::*;

    logic  clk;
    logic  rst;
    word_t instrAddr;
    word_t instr;
    word_t memAddr;
    word_t memWriteData;
    logic  memWrite;
    word_t memReadData;
    word_t a0;

    word_t rom [64];
    word_t dataMem [64];
    word_t refMem [64];
    word_t refRegs [32];
    word_t expAddr [$];
    word_t expData [$];
    word_t expA0;
    word_t haltAddr;
    int    storeIdx = 0;
    int    cycles;
    int    settled;

    pipelineCpu DUT (
        .clk          (clk),
        .rst          (rst),
        .instrAddr    (instrAddr),
        .instr        (instr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memReadData  (memReadData),
        .a0           (a0)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // both memories answer combinationally and the data RAM writes on the edge
    assign instr       = rom[instrAddr[7:2]];
    assign memReadData = dataMem[memAddr[7:2]];

    always @(posedge clk) begin
        if (memWrite === 1'b1) begin
            dataMem[memAddr[7:2]] <= memWriteData;
        end
    end

    task automatic reportMismatch(string name, word_t got, word_t exp);
        $display("Testbench failed");
        $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic failWith(string what);
        $display("Testbench failed");
        $display("%s (at %0t ns)", what, $time);
        $fatal(1, "stopping at the first failure");
    endtask

    // small assembler for the supported formats
    function automatic word_t encodeR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t encodeI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encodeS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t encodeB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t encodeJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    task automatic loadProgram();
        // unused slots hold addi x0 nops that differ by address
        for (int i = 0; i < 64; i++) begin
            rom[i] = encodeI(i[11:0], 5'd0, 3'b000, 5'd0, 7'h13);
        end
        rom[0]  = encodeI(12'd0, 5'd0, 3'b010, 5'd1, 7'h03);
        rom[1]  = encodeI(12'd4, 5'd0, 3'b010, 5'd2, 7'h03);
        // load-use on x2
        rom[2]  = encodeR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        rom[3]  = encodeS(12'd64, 5'd3, 5'd0);
        rom[4]  = encodeR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
        rom[5]  = encodeR(7'h00, 5'd1, 5'd4, 3'b111, 5'd5);
        // x5 comes from the memory stage and x4 from writeback
        rom[6]  = encodeR(7'h00, 5'd4, 5'd5, 3'b110, 5'd6);
        rom[7]  = encodeR(7'h00, 5'd2, 5'd1, 3'b010, 5'd7);
        rom[8]  = encodeR(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);
        rom[9]  = encodeS(12'd68, 5'd4, 5'd0);
        rom[10] = encodeS(12'd72, 5'd5, 5'd0);
        rom[11] = encodeS(12'd76, 5'd6, 5'd0);
        rom[12] = encodeS(12'd80, 5'd7, 5'd0);
        rom[13] = encodeS(12'd84, 5'd8, 5'd0);
        rom[14] = encodeI(12'd8, 5'd0, 3'b010, 5'd9, 7'h03);
        rom[15] = encodeR(7'h00, 5'd1, 5'd9, 3'b000, 5'd10);
        rom[16] = encodeS(12'd88, 5'd10, 5'd0);
        rom[17] = encodeI(12'd5, 5'd0, 3'b000, 5'd11, 7'h13);
        rom[18] = encodeI(12'd5, 5'd0, 3'b000, 5'd12, 7'h13);
        // taken branch over two stores
        rom[19] = encodeB(13'd12, 5'd12, 5'd11);
        rom[20] = encodeS(12'd92, 5'd1, 5'd0);
        rom[21] = encodeS(12'd96, 5'd2, 5'd0);
        rom[22] = encodeJ(21'd8, 5'd13);
        rom[23] = encodeS(12'd100, 5'd1, 5'd0);
        rom[24] = encodeS(12'd104, 5'd13, 5'd0);
        rom[25] = encodeI(12'd120, 5'd0, 3'b000, 5'd14, 7'h13);
        rom[26] = encodeI(12'd0, 5'd14, 3'b000, 5'd15, 7'h67);
        rom[27] = encodeS(12'd108, 5'd1, 5'd0);
        rom[28] = encodeS(12'd112, 5'd2, 5'd0);
        rom[29] = encodeI(12'd1, 5'd0, 3'b000, 5'd10, 7'h13);
        rom[30] = encodeS(12'd116, 5'd15, 5'd0);
        rom[31] = encodeI(12'd3, 5'd10, 3'b000, 5'd10, 7'h13);
        // jal to itself
        rom[32] = encodeJ(21'd0, 5'd0);
    endtask

    // executes one instruction per step straight from the RV32I encoding
    task automatic runModel();
        word_t pc;
        word_t nextPc;
        word_t ins;
        word_t a;
        word_t b;
        word_t val;
        word_t immI;
        word_t immS;
        word_t immB;
        word_t immJ;
        logic  wr;
        int    steps;
        pc = '0;
        steps = 0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        while (steps < 200) begin
            ins  = rom[pc[7:2]];
            a    = refRegs[ins[19:15]];
            b    = refRegs[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            if (ins[6:0] == 7'h6F && immJ == '0) begin
                break;
            end
            nextPc = pc + 4;
            wr = 1'b1;
            val = '0;
            if (ins[6:0] == 7'h13) begin
                b = immI;
            end
            case (ins[6:0])
                7'h33, 7'h13: begin
                    case (ins[14:12])
                        3'b000: val = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                        3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b110: val = a | b;
                        3'b111: val = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'h03: val = refMem[(a + immI) >> 2];
                7'h23: begin
                    wr = 1'b0;
                    refMem[(a + immS) >> 2] = b;
                    expAddr.push_back(a + immS);
                    expData.push_back(b);
                end
                7'h63: begin
                    wr = 1'b0;
                    if (a == b) begin
                        nextPc = pc + immB;
                    end
                end
                7'h6F: begin
                    val = pc + 4;
                    nextPc = pc + immJ;
                end
                7'h67: begin
                    val = pc + 4;
                    nextPc = (a + immI) & ~32'd1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                refRegs[ins[11:7]] = val;
            end
            pc = nextPc;
            steps++;
        end
        haltAddr = pc;
        expA0 = refRegs[10];
    endtask

    // each store must be the next one the model made
    always @(posedge clk) begin
        if (!rst) begin
            assert (!$isunknown(memWrite)) else failWith("memWrite is unknown after reset");
            if (memWrite) begin
                assert (storeIdx < expAddr.size())
                    else failWith("a store appeared that the reference model never made");
                assert (memAddr === expAddr[storeIdx])
                    else reportMismatch("memAddr", memAddr, expAddr[storeIdx]);
                assert (memWriteData === expData[storeIdx])
                    else reportMismatch("memWriteData", memWriteData, expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    initial begin
        rst = 1'b1;
        void'($urandom(86961));
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = (i < 8) ? $urandom() : (32'hA5C3_0000 ^ (i * 4));
            refMem[i] = dataMem[i];
        end
        loadProgram();
        runModel();

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (instrAddr === '0) else reportMismatch("instrAddr", instrAddr, '0);
        assert (memWrite === 1'b0) else reportMismatch("memWrite", {31'b0, memWrite}, '0);

        // the self jal refetches every third cycle, so watch the halt window
        cycles = 0;
        settled = 0;
        while (settled < 20 && cycles < 500) begin
            @(posedge clk);
            cycles++;
            if (instrAddr >= haltAddr && instrAddr <= haltAddr + 8) begin
                settled++;
            end else begin
                settled = 0;
            end
        end
        #1;
        assert (settled >= 20) else failWith("the pipeline never reached its halt");
        assert (storeIdx == expAddr.size())
            else failWith("fewer stores were seen than the reference model made");
        assert (a0 === expA0) else reportMismatch("a0", a0, expA0);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
